//--- cache_mem_system.f
cache_pkg.sv
mem_pkg.sv
cache_array.sv
cache_core.sv
main_mem.sv
cache_ctrl.sv
cache_mem_system.sv
clk_gen.sv
cache_mem_system_sva.sv
tb_cache_mem_system.sv

//--- run.sh
#!/bin/sh
# Builds and runs the cache testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_cache_mem_system -f cache_mem_system.f

status=0
output=$(./obj_dir/Vtb_cache_mem_system) || status=$?
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
   exit 0
fi
echo "Simulation did not pass, exit status $status"
exit 1

//--- tb_cache_mem_system.sv
// One request in flight at a time, main memory assumed zero at start, run limited by a cycle count
`timescale 1ns/10ps
`default_nettype none

module tb_cache_mem_system;
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int N_BP = 40;
   localparam int N_RANDOM = 400;
   localparam int N_OPS = 450;
   // Worst case is a dirty eviction, four write-backs and four fills
   localparam int OP_CYCLES = 2 * WORDS_PER_LINE * (MEM_LATENCY + 2) + 6;
   // A quarter extra for back-pressure stalls
   localparam int TIMEOUT_CYCLES = N_OPS * OP_CYCLES * 5 / 4;

   logic              clk;
   logic              rst_n;
   logic              req_valid;
   logic              req_ready;
   logic              req_write;
   logic [ADDR_W-1:0] req_addr;
   logic [WORD_W-1:0] req_wdata;
   logic              resp_valid;
   logic              resp_ready;
   logic [WORD_W-1:0] resp_rdata;
   logic              resp_hit;
   logic              resp_err;

   integer seed = 32'hfbd;

   // Reference model, flat word memory plus tag and valid per index
   bit   [WORD_W-1:0] model_mem [MEM_DEPTH];
   bit   [TAG_W-1:0]  model_tag [LINES];
   bit   [LINES-1:0]  model_valid;

   // Expected responses packed as {err, hit, rdata}
   logic [WORD_W+1:0] exp_q [$];
   logic [WORD_W+1:0] expected;
   int                acc_count;
   int                resp_count;
   int                mon_checks;
   int                mon_errors;
   bit                mon_bad;
   int                dir_checks;
   int                dir_errors;
   bit                dir_bad;
   logic              last_hit;
   logic              last_err;
   logic [WORD_W-1:0] last_rdata;
   bit                bp_on;
   int                stall_len [64];
   int                stall_left;
   int                stall_pos;
   int                cycles;

   clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

   cache_mem_system cache_mem_system_inst (
      .clk(clk), .rst_n(rst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
      .req_addr(req_addr), .req_wdata(req_wdata),
      .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata),
      .resp_hit(resp_hit), .resp_err(resp_err)
   );

   bind cache_ctrl cache_mem_system_sva sva_inst (
      .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
      .req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
      .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata),
      .resp_hit(resp_hit), .resp_err(resp_err), .mem_start(mem_start),
      .mem_done(mem_done)
   );

   function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [INDEX_W-1:0] idx,
                                                   input logic [1:0] word);
      return {tag, idx, word, 1'b0};
   endfunction

   // Expected response of one access, the model is updated as the cache would be
   function automatic logic [WORD_W+1:0] model_access(input logic write,
                                                      input logic [ADDR_W-1:0] addr,
                                                      input logic [WORD_W-1:0] wdata);
      logic [TAG_W-1:0]      tag;
      logic [INDEX_W-1:0]    idx;
      logic [MEM_ADDR_W-1:0] waddr;
      logic                  hit;
      tag = addr[ADDR_W-1 -: TAG_W];
      idx = addr[OFFSET_W +: INDEX_W];
      waddr = addr[ADDR_W-1:1];
      // Odd address is refused and changes nothing
      if (addr[0]) begin
         return {1'b1, 1'b0, {WORD_W{1'b0}}};
      end
      hit = model_valid[idx] && (model_tag[idx] == tag);
      model_valid[idx] = 1'b1;
      model_tag[idx] = tag;
      if (write) begin
         model_mem[waddr] = wdata;
      end
      return {1'b0, hit, model_mem[waddr]};
   endfunction

   task automatic check_value(input string what, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] want, output bit bad);
      bad = (got !== want);
      if (bad) begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   // Compare process, every handshake is checked against the model
   always @(posedge clk) begin
      if (rst_n) begin
         if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
               mon_errors++;
               $display("Response at %0t came with no request outstanding", $time);
            end else begin
               expected = exp_q.pop_front();
               mon_checks += 3;
               check_value("resp_rdata", resp_rdata, expected[WORD_W-1:0], mon_bad);
               if (mon_bad) mon_errors++;
               check_value("resp_hit", 16'(resp_hit), 16'(expected[WORD_W]), mon_bad);
               if (mon_bad) mon_errors++;
               check_value("resp_err", 16'(resp_err), 16'(expected[WORD_W+1]), mon_bad);
               if (mon_bad) mon_errors++;
            end
            last_rdata = resp_rdata;
            last_hit = resp_hit;
            last_err = resp_err;
            resp_count++;
         end
         if (req_valid && req_ready) begin
            if (exp_q.size() != 0) begin
               mon_errors++;
               $display("Request accepted at %0t while a response was pending", $time);
            end
            exp_q.push_back(model_access(req_write, req_addr, req_wdata));
            acc_count++;
         end
      end
   end

   // Response back-pressure, low stretches taken from a table filled by the stimulus
   initial begin
      resp_ready = 1'b1;
      forever begin
         @(negedge clk);
         if (!bp_on) begin
            resp_ready = 1'b1;
            stall_left = 0;
         end else if (stall_left != 0) begin
            resp_ready = 1'b0;
            stall_left--;
         end else begin
            resp_ready = 1'b1;
            stall_left = stall_len[stall_pos];
            stall_pos = (stall_pos + 1) % 64;
         end
      end
   end

   initial begin
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("TEST FAILED");
      $finish;
   end

   // Called at a falling edge, returns at the falling edge after acceptance
   task automatic send(input logic write, input logic [ADDR_W-1:0] addr,
                       input logic [WORD_W-1:0] wdata, input bit wait_resp);
      int target;
      target = acc_count + 1;
      req_valid = 1'b1;
      req_write = write;
      req_addr = addr;
      req_wdata = wdata;
      do @(negedge clk); while (acc_count < target);
      req_valid = 1'b0;
      if (wait_resp) begin
         while (resp_count < acc_count) @(negedge clk);
      end
   endtask

   task automatic expect_resp(input logic hit, input logic err, input logic [WORD_W-1:0] rdata);
      dir_checks += 3;
      check_value("directed rdata", last_rdata, rdata, dir_bad);
      if (dir_bad) dir_errors++;
      check_value("directed hit", 16'(last_hit), 16'(hit), dir_bad);
      if (dir_bad) dir_errors++;
      check_value("directed err", 16'(last_err), 16'(err), dir_bad);
      if (dir_bad) dir_errors++;
   endtask

   // Few indexes and tags so that hits, misses and evictions all occur
   task automatic random_op(input bit wait_resp);
      logic [ADDR_W-1:0] addr;
      logic              write;
      logic [WORD_W-1:0] wdata;
      addr = make_addr(5'($random(seed) & 3), 8'(8'h20 + ($random(seed) & 3)),
                       2'($random(seed)));
      write = 1'($random(seed));
      wdata = 16'($random(seed));
      if (($random(seed) & 15) == 0) begin
         addr[0] = 1'b1;
      end
      send(write, addr, wdata, wait_resp);
   endtask

   initial begin
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr = '0;
      req_wdata = '0;
      bp_on = 1'b0;
      wait (rst_n === 1'b1);
      @(negedge clk);

      // Cold miss reads zero, then the same word hits
      send(1'b0, make_addr(5'd1, 8'd5, 2'd0), '0, 1'b1);
      expect_resp(1'b0, 1'b0, 16'h0000);
      send(1'b0, make_addr(5'd1, 8'd5, 2'd0), '0, 1'b1);
      expect_resp(1'b1, 1'b0, 16'h0000);

      // Write allocate, then read back and read the neighbor word
      send(1'b1, make_addr(5'd2, 8'd6, 2'd1), 16'h1234, 1'b1);
      expect_resp(1'b0, 1'b0, 16'h1234);
      send(1'b0, make_addr(5'd2, 8'd6, 2'd1), '0, 1'b1);
      expect_resp(1'b1, 1'b0, 16'h1234);
      send(1'b0, make_addr(5'd2, 8'd6, 2'd2), '0, 1'b1);
      expect_resp(1'b1, 1'b0, 16'h0000);

      // Dirty line evicted by another tag comes back from memory
      send(1'b1, make_addr(5'd3, 8'd7, 2'd0), 16'h5a5a, 1'b1);
      expect_resp(1'b0, 1'b0, 16'h5a5a);
      send(1'b0, make_addr(5'd4, 8'd7, 2'd0), '0, 1'b1);
      expect_resp(1'b0, 1'b0, 16'h0000);
      send(1'b0, make_addr(5'd3, 8'd7, 2'd0), '0, 1'b1);
      expect_resp(1'b0, 1'b0, 16'h5a5a);

      // Odd address write is refused and leaves the line alone
      send(1'b1, make_addr(5'd3, 8'd7, 2'd0) | 16'h0001, 16'hffff, 1'b1);
      expect_resp(1'b0, 1'b1, 16'h0000);
      send(1'b0, make_addr(5'd3, 8'd7, 2'd0), '0, 1'b1);
      expect_resp(1'b1, 1'b0, 16'h5a5a);

      // Back-to-back requests against a stalled response
      for (int i = 0; i < 64; i++) begin
         stall_len[i] = $random(seed) & 7;
      end
      bp_on = 1'b1;
      for (int i = 0; i < N_BP; i++) begin
         random_op(1'b0);
      end
      while (resp_count < acc_count) @(negedge clk);
      bp_on = 1'b0;

      for (int i = 0; i < N_RANDOM; i++) begin
         random_op(1'b1);
      end

      $display("Requests %0d, checks %0d, errors %0d", acc_count,
               mon_checks + dir_checks, mon_errors + dir_errors);
      if ((mon_errors + dir_errors) == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- cache_mem_system_sva.sv
// Handshake checks for cache_ctrl, expects a single memory access outstanding at a time
`timescale 1ns/10ps
`default_nettype none

module cache_mem_system_sva (
   input logic                           clk,
   input logic                           rst_n,
   input logic                           req_valid,
   input logic                           req_ready,
   input logic                           req_write,
   input logic [cache_pkg::ADDR_W-1:0]   req_addr,
   input logic [cache_pkg::WORD_W-1:0]   req_wdata,
   input logic                           resp_valid,
   input logic                           resp_ready,
   input logic [cache_pkg::WORD_W-1:0]   resp_rdata,
   input logic                           resp_hit,
   input logic                           resp_err,
   input logic                           mem_start,
   input logic                           mem_done
);
   import mem_pkg::*;

   logic mem_pending;

   // Outstanding from the start pulse until the done pulse
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_pending <= 1'b0;
      end else if (mem_start) begin
         mem_pending <= 1'b1;
      end else if (mem_done) begin
         mem_pending <= 1'b0;
      end
   end

   req_held: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid && !req_ready) |=> (req_valid && $stable(req_write) &&
                                     $stable(req_addr) && $stable(req_wdata)))
      else $error("Request changed while waiting for req_ready");

   resp_held: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_rdata) &&
                                       $stable(resp_hit) && $stable(resp_err)))
      else $error("Response changed while waiting for resp_ready");

   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> (!resp_valid && !mem_start))
      else $error("resp_valid or mem_start high right after reset");

   single_access: assert property (@(posedge clk) disable iff (!rst_n)
      mem_start |-> !mem_pending)
      else $error("mem_start while a memory access is outstanding");

   // Fixed latency of the memory model
   done_latency: assert property (@(posedge clk) disable iff (!rst_n)
      mem_start |-> ##MEM_LATENCY mem_done)
      else $error("mem_done did not follow mem_start after the memory latency");

endmodule

`default_nettype wire

//--- clk_gen.sv
// Free-running 20 ns clock, synchronous active-low reset released at a falling edge after 2 cycles
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD = 10;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset covers two rising edges
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- cache_mem_system.sv
// Top level with loose CPU ports, one request at a time, memory latency set in the memory package
`timescale 1ns/10ps
`default_nettype none

module cache_mem_system (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          req_valid,
   output logic                          req_ready,
   input  logic                          req_write,
   input  logic [cache_pkg::ADDR_W-1:0]  req_addr,
   input  logic [cache_pkg::WORD_W-1:0]  req_wdata,
   output logic                          resp_valid,
   input  logic                          resp_ready,
   output logic [cache_pkg::WORD_W-1:0]  resp_rdata,
   output logic                          resp_hit,
   output logic                          resp_err
);
   import cache_pkg::*;
   import mem_pkg::*;

   // Controller to core
   logic                  enable;
   cache_op_t             core_op;
   logic [TAG_W-1:0]      tag_in;
   logic [INDEX_W-1:0]    index;
   logic [OFFSET_W-1:0]   offset;
   logic [WORD_W-1:0]     data_in;
   logic [TAG_W-1:0]      tag_out;
   logic [WORD_W-1:0]     data_out;
   logic                  hit;
   logic                  dirty;
   logic                  valid;
   logic                  err;

   // Controller to memory
   logic                  mem_start;
   mem_op_t               mem_op;
   logic [MEM_ADDR_W-1:0] mem_addr;
   logic [MEM_DATA_W-1:0] mem_wdata;
   logic [MEM_DATA_W-1:0] mem_rdata;
   logic                  mem_done;

   cache_ctrl ctrl_inst (
      .clk(clk), .rst_n(rst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
      .req_addr(req_addr), .req_wdata(req_wdata),
      .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata),
      .resp_hit(resp_hit), .resp_err(resp_err),
      .enable(enable), .core_op(core_op), .tag_in(tag_in), .index(index),
      .offset(offset), .data_in(data_in), .tag_out(tag_out), .data_out(data_out),
      .hit(hit), .dirty(dirty), .valid(valid), .err(err),
      .mem_start(mem_start), .mem_op(mem_op), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_done(mem_done)
   );

   cache_core core_inst (
      .clk(clk), .rst_n(rst_n), .enable(enable), .core_op(core_op),
      .tag_in(tag_in), .index(index), .offset(offset), .data_in(data_in),
      .tag_out(tag_out), .data_out(data_out), .hit(hit), .dirty(dirty),
      .valid(valid), .err(err)
   );

   main_mem mem_inst (
      .clk(clk), .rst_n(rst_n), .mem_start(mem_start), .mem_op(mem_op),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
      .mem_done(mem_done)
   );

endmodule

`default_nettype wire

//--- cache_ctrl.sv
// One request in flight, the response is held until taken, and a dirty victim is written back whole
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            req_valid,
   output logic                            req_ready,
   input  logic                            req_write,
   input  logic [cache_pkg::ADDR_W-1:0]    req_addr,
   input  logic [cache_pkg::WORD_W-1:0]    req_wdata,
   output logic                            resp_valid,
   input  logic                            resp_ready,
   output logic [cache_pkg::WORD_W-1:0]    resp_rdata,
   output logic                            resp_hit,
   output logic                            resp_err,
   output logic                            enable,
   output cache_pkg::cache_op_t            core_op,
   output logic [cache_pkg::TAG_W-1:0]     tag_in,
   output logic [cache_pkg::INDEX_W-1:0]   index,
   output logic [cache_pkg::OFFSET_W-1:0]  offset,
   output logic [cache_pkg::WORD_W-1:0]    data_in,
   input  logic [cache_pkg::TAG_W-1:0]     tag_out,
   input  logic [cache_pkg::WORD_W-1:0]    data_out,
   input  logic                            hit,
   input  logic                            dirty,
   input  logic                            valid,
   input  logic                            err,
   output logic                            mem_start,
   output mem_pkg::mem_op_t                mem_op,
   output logic [mem_pkg::MEM_ADDR_W-1:0]  mem_addr,
   output logic [mem_pkg::MEM_DATA_W-1:0]  mem_wdata,
   input  logic [mem_pkg::MEM_DATA_W-1:0]  mem_rdata,
   input  logic                            mem_done
);
   import cache_pkg::*;
   import mem_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITEBACK,
      FILL,
      RESPOND
   } ctrl_state_t;

   ctrl_state_t           state;
   logic                  req_write_q;
   logic [ADDR_W-1:0]     addr_q;
   logic [WORD_W-1:0]     wdata_q;
   logic                  first_q;
   logic                  mem_busy;
   logic [WORD_SEL_W-1:0] word_cnt;
   logic                  last_word;
   logic [WORD_W-1:0]     rdata_q;
   logic                  hit_q;
   logic                  err_q;
   logic [TAG_W-1:0]      req_tag;
   logic [INDEX_W-1:0]    req_index;

   assign req_tag = addr_q[ADDR_W-1 -: TAG_W];
   assign req_index = addr_q[OFFSET_W +: INDEX_W];
   assign last_word = (word_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1));

   assign req_ready = (state == IDLE);
   assign resp_valid = (state == RESPOND);
   assign resp_rdata = rdata_q;
   assign resp_hit = hit_q;
   assign resp_err = err_q;

   assign tag_in = req_tag;
   assign index = req_index;

   // Core access per state, the fill write waits for the memory word
   always_comb begin
      enable = 1'b0;
      core_op = RAW_READ;
      offset = addr_q[OFFSET_W-1:0];
      data_in = wdata_q;
      case (state)
         LOOKUP: begin
            enable = 1'b1;
            core_op = req_write_q ? CMP_WRITE : CMP_READ;
         end
         WRITEBACK: begin
            enable = 1'b1;
            offset = {word_cnt, 1'b0};
         end
         FILL: begin
            enable = mem_done;
            core_op = FILL_WRITE;
            offset = {word_cnt, 1'b0};
            data_in = mem_rdata;
         end
         default: begin
         end
      endcase
   end

   // One start per word, the next only after done
   assign mem_start = ((state == WRITEBACK) || (state == FILL)) && !mem_busy;
   assign mem_op = (state == WRITEBACK) ? MEM_WRITE : MEM_READ;
   // Victim address comes from the stored tag
   assign mem_addr = (state == WRITEBACK) ? {tag_out, req_index, word_cnt}
                                          : {req_tag, req_index, word_cnt};
   assign mem_wdata = data_out;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
         first_q <= 1'b0;
         mem_busy <= 1'b0;
         word_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (req_valid) begin
                  state <= LOOKUP;
                  first_q <= 1'b1;
               end
            end
            LOOKUP: begin
               first_q <= 1'b0;
               if (err || hit) begin
                  state <= RESPOND;
               end else begin
                  word_cnt <= '0;
                  state <= (valid && dirty) ? WRITEBACK : FILL;
               end
            end
            WRITEBACK, FILL: begin
               if (!mem_busy) begin
                  mem_busy <= 1'b1;
               end else if (mem_done) begin
                  mem_busy <= 1'b0;
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word) begin
                     // After the fill the lookup is repeated and now hits
                     state <= (state == WRITEBACK) ? FILL : LOOKUP;
                  end
               end
            end
            RESPOND: begin
               if (resp_ready) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Request capture and response fields
   always_ff @(posedge clk) begin
      if ((state == IDLE) && req_valid) begin
         req_write_q <= req_write;
         addr_q <= req_addr;
         wdata_q <= req_wdata;
      end
      if (state == LOOKUP) begin
         // Hit flag reflects the first lookup only
         if (first_q) begin
            hit_q <= hit && !err;
         end
         err_q <= err;
         rdata_q <= err ? '0 : (req_write_q ? wdata_q : data_out);
      end
   end

endmodule

`default_nettype wire

//--- main_mem.sv
// Simulation memory model starting at zero, a start while busy is not allowed and is ignored
`timescale 1ns/10ps
`default_nettype none

module main_mem (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            mem_start,
   input  mem_pkg::mem_op_t                mem_op,
   input  logic [mem_pkg::MEM_ADDR_W-1:0]  mem_addr,
   input  logic [mem_pkg::MEM_DATA_W-1:0]  mem_wdata,
   output logic [mem_pkg::MEM_DATA_W-1:0]  mem_rdata,
   output logic                            mem_done
);
   import mem_pkg::*;

   localparam int CNT_W = $clog2(MEM_LATENCY + 1);

   logic [MEM_DATA_W-1:0] mem [MEM_DEPTH];
   logic                  busy;
   logic [CNT_W-1:0]      cnt;
   mem_op_t               op_q;
   logic [MEM_ADDR_W-1:0] addr_q;
   logic [MEM_DATA_W-1:0] wdata_q;

   initial begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Latency counter, done lands MEM_LATENCY cycles after the start cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt <= '0;
      end else if (!busy) begin
         if (mem_start) begin
            busy <= 1'b1;
            cnt <= CNT_W'(MEM_LATENCY - 1);
         end
      end else if (cnt == '0) begin
         busy <= 1'b0;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // Captured access fields
   always_ff @(posedge clk) begin
      if (!busy && mem_start) begin
         op_q <= mem_op;
         addr_q <= mem_addr;
         wdata_q <= mem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_done && (op_q == MEM_WRITE)) begin
         mem[addr_q] <= wdata_q;
      end
   end

   assign mem_done = busy && (cnt == '0);
   assign mem_rdata = mem[addr_q];

endmodule

`default_nettype wire

//--- cache_core.sv
// Outputs are combinational and writes land on the next edge, an odd offset blocks all writes
`timescale 1ns/10ps
`default_nettype none

module cache_core (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           enable,
   input  cache_pkg::cache_op_t           core_op,
   input  logic [cache_pkg::TAG_W-1:0]    tag_in,
   input  logic [cache_pkg::INDEX_W-1:0]  index,
   input  logic [cache_pkg::OFFSET_W-1:0] offset,
   input  logic [cache_pkg::WORD_W-1:0]   data_in,
   output logic [cache_pkg::TAG_W-1:0]    tag_out,
   output logic [cache_pkg::WORD_W-1:0]   data_out,
   output logic                           hit,
   output logic                           dirty,
   output logic                           valid,
   output logic                           err
);
   import cache_pkg::*;

   logic                  comp;
   logic                  write;
   logic                  match;
   logic                  hit_int;
   logic                  wr_word_any;
   logic                  wr_fill;
   logic                  dirty_in;
   logic                  dirty_bit;
   logic [WORD_SEL_W-1:0] word_sel;
   logic [WORD_W-1:0]     words [WORDS_PER_LINE];
   logic [LINES-1:0]      valid_q;

   // Decode the access kind into compare and write controls
   assign comp = (core_op == CMP_READ) || (core_op == CMP_WRITE);
   assign write = (core_op == CMP_WRITE) || (core_op == FILL_WRITE);

   assign err = offset[0];
   assign word_sel = offset[OFFSET_W-1:1];
   assign match = (tag_in == tag_out);
   assign hit_int = valid_q[index] && match;

   // Compare write needs a hit, fill writes unconditionally
   assign wr_word_any = enable && write && !err && (hit_int || !comp);
   assign wr_fill = enable && write && !err && !comp;

   // Compare write marks the line dirty, a fill leaves it clean
   assign dirty_in = comp;

   for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_word
      cache_array #(.width(WORD_W)) word_inst (
         .clk   (clk),
         .index (index),
         .wdata (data_in),
         .we    (wr_word_any && (word_sel == WORD_SEL_W'(w))),
         .rdata (words[w])
      );
   end

   cache_array #(.width(TAG_W)) tag_inst (
      .clk   (clk),
      .index (index),
      .wdata (tag_in),
      .we    (wr_fill),
      .rdata (tag_out)
   );

   cache_array #(.width(1)) dirty_inst (
      .clk   (clk),
      .index (index),
      .wdata (dirty_in),
      .we    (wr_word_any),
      .rdata (dirty_bit)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (wr_fill) begin
         valid_q[index] <= 1'b1;
      end
   end

   assign hit = enable && hit_int;
   assign valid = enable && valid_q[index];
   // Dirty bits of never-filled lines hold no meaning
   assign dirty = enable && valid_q[index] && dirty_bit;
   assign data_out = enable ? words[word_sel] : '0;

endmodule

`default_nettype wire

//--- cache_array.sv
// Contents are not reset, so a reader must qualify them with a separate valid bit
`timescale 1ns/10ps
`default_nettype none

module cache_array #(
   parameter int width = 16
) (
   input  logic                          clk,
   input  logic [cache_pkg::INDEX_W-1:0] index,
   input  logic [width-1:0]              wdata,
   input  logic                          we,
   output logic [width-1:0]              rdata
);
   import cache_pkg::*;

   logic [width-1:0] mem [LINES];

   // Read is combinational so the core can compare in the same cycle
   assign rdata = mem[index];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[index] <= wdata;
      end
   end

endmodule

`default_nettype wire

//--- mem_pkg.sv
// Main memory is word addressed, one access outstanding, fixed latency from start to done
`default_nettype none

package mem_pkg;

   // Word address covers tag, index and word select of the cache address
   localparam int MEM_ADDR_W = 15;

   // Word width must match the cache word
   localparam int MEM_DATA_W = 16;

   localparam int MEM_DEPTH = 2 ** MEM_ADDR_W;

   // Cycles from the start pulse to the done pulse
   localparam int MEM_LATENCY = 4;

   // Memory access kinds
   typedef enum logic {
      MEM_READ,
      MEM_WRITE
   } mem_op_t;

endpackage

`default_nettype wire

//--- cache_pkg.sv
// Cache geometry assumes a 16-bit byte address with word-aligned accesses and four words per line
`default_nettype none

package cache_pkg;

   // Address split, most significant field first
   localparam int TAG_W = 5;
   localparam int INDEX_W = 8;
   localparam int OFFSET_W = 3;
   localparam int ADDR_W = TAG_W + INDEX_W + OFFSET_W;

   // Line shape
   localparam int WORD_W = 16;
   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
   localparam int LINES = 2 ** INDEX_W;

   // Core access kinds
   // CMP_* act only on a valid tag match, FILL_WRITE loads a word of a new line
   // RAW_READ returns the stored word and tag without any compare
   typedef enum logic [1:0] {
      CMP_READ,
      CMP_WRITE,
      FILL_WRITE,
      RAW_READ
   } cache_op_t;

endpackage

`default_nettype wire
